// ==== design/core_pkg.sv ====
package core_pkg;

    //////////////////////////////////////////////////
    // widths and sizes
    //////////////////////////////////////////////////

    localparam int XLEN       = 32;
    localparam int REG_AW     = 5;
    localparam int IMEM_WORDS = 64;
    localparam int IMEM_AW    = 6;
    localparam int APB_AW     = 12;

    //////////////////////////////////////////////////
    // rv32i opcodes kept by this core
    //////////////////////////////////////////////////

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // full word, funct12 = 1
    localparam logic [XLEN-1:0] INSTR_EBREAK = 32'h0010_0073;

    //////////////////////////////////////////////////
    // apb address map
    //////////////////////////////////////////////////

    // imem words 0..63 at 0x000..0x0fc
    localparam logic [APB_AW-1:0] ADDR_IMEM_BASE = 12'h000;
    localparam logic [APB_AW-1:0] ADDR_CTRL      = 12'h100;
    localparam logic [APB_AW-1:0] ADDR_STATUS    = 12'h104;
    localparam logic [APB_AW-1:0] ADDR_INSTRET   = 12'h108;
    // x0..x31 at 0x180..0x1fc
    localparam logic [APB_AW-1:0] ADDR_REG_BASE  = 12'h180;

    //////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////

    // pass_b carries the lui immediate through
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [APB_AW-1:0] paddr;
        logic [XLEN-1:0]   pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [XLEN-1:0] prdata;
        logic            pready;
        logic            pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [XLEN-1:0]   rs1_data;
        logic [XLEN-1:0]   rs2_data;
        logic [XLEN-1:0]   imm;
        alu_op_e           alu_op;
        logic              use_imm;
        logic              is_branch;
        logic              branch_ne;
        logic              is_ebreak;
        logic [REG_AW-1:0] rd;
        logic              wr_en;
    } id_ex_t;

    typedef struct packed {
        logic              valid;
        logic [REG_AW-1:0] rd;
        logic              wr_en;
        logic [XLEN-1:0]   result;
    } ex_wb_t;

    // taken branch, execute to fetch
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic              en;
        logic [REG_AW-1:0] addr;
        logic [XLEN-1:0]   data;
    } rf_wr_t;

endpackage

// ==== design/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  core_pkg::if_id_t            i_if_id,
    input  logic                        i_squash,
    input  logic [core_pkg::XLEN-1:0]   i_rs1_data,
    input  logic [core_pkg::XLEN-1:0]   i_rs2_data,
    output logic [core_pkg::REG_AW-1:0] o_rs1_addr,
    output logic [core_pkg::REG_AW-1:0] o_rs2_addr,
    output core_pkg::id_ex_t            o_id_ex
);
    import core_pkg::*;

    logic [XLEN-1:0] instr;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            alt;
    logic [XLEN-1:0] imm_i, imm_u, imm_b;
    logic            supported;
    id_ex_t          dec;

    assign instr      = i_if_id.instr;
    assign opcode     = instr[6:0];
    assign funct3     = instr[14:12];
    // funct7 bit 5, sub and sra
    assign alt        = instr[30];
    assign o_rs1_addr = instr[19:15];
    assign o_rs2_addr = instr[24:20];

    //////////////////////////////////////////////////
    // immediates
    //////////////////////////////////////////////////

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic sub_sra);
        case (f3)
            3'b000:  return sub_sra ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return sub_sra ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // decoder
    //////////////////////////////////////////////////

    always_comb
    begin
        dec          = '0;
        dec.pc       = i_if_id.pc;
        dec.rs1      = o_rs1_addr;
        dec.rs2      = o_rs2_addr;
        dec.rs1_data = i_rs1_data;
        dec.rs2_data = i_rs2_data;
        dec.rd       = instr[11:7];
        supported    = 1'b1;
        case (opcode)
            OPC_OP:
            begin
                dec.alu_op = alu_from_funct(funct3, alt);
                dec.wr_en  = 1'b1;
            end
            OPC_OP_IMM:
            begin
                // bit 30 only means srai, addi keeps its imm
                dec.alu_op  = alu_from_funct(funct3, alt & (funct3 == 3'b101));
                dec.imm     = imm_i;
                dec.use_imm = 1'b1;
                dec.wr_en   = 1'b1;
            end
            OPC_LUI:
            begin
                dec.alu_op  = ALU_PASS_B;
                dec.imm     = imm_u;
                dec.use_imm = 1'b1;
                dec.wr_en   = 1'b1;
            end
            OPC_BRANCH:
            begin
                // beq and bne only
                dec.imm       = imm_b;
                dec.is_branch = 1'b1;
                dec.branch_ne = funct3[0];
                supported     = (funct3[2:1] == 2'b00);
            end
            OPC_SYSTEM:
            begin
                dec.is_ebreak = 1'b1;
                supported     = (instr == INSTR_EBREAK);
            end
            default:
                supported = 1'b0;
        endcase
        // anything else leaves as a bubble
        dec.valid = i_if_id.valid & supported & ~i_squash;
    end

    // decode to execute register
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            o_id_ex.valid <= 1'b0;
        else
            o_id_ex <= dec;
    end

endmodule

// ==== design/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  core_pkg::id_ex_t    i_id_ex,
    output core_pkg::ex_wb_t    o_ex_wb,
    output core_pkg::redirect_t o_redirect,
    output logic                o_halt_req,
    output logic                o_pipe_busy
);
    import core_pkg::*;

    logic            fwd_rs1, fwd_rs2;
    logic [XLEN-1:0] op_a, rs2_val, op_b;
    logic [XLEN-1:0] alu_out;

    //////////////////////////////////////////////////
    // forwarding from writeback
    //////////////////////////////////////////////////

    // older writes already sit in the register file
    assign fwd_rs1 = o_ex_wb.valid & o_ex_wb.wr_en & (o_ex_wb.rd != '0)
                   & (o_ex_wb.rd == i_id_ex.rs1);
    assign fwd_rs2 = o_ex_wb.valid & o_ex_wb.wr_en & (o_ex_wb.rd != '0)
                   & (o_ex_wb.rd == i_id_ex.rs2);

    assign op_a    = fwd_rs1 ? o_ex_wb.result : i_id_ex.rs1_data;
    assign rs2_val = fwd_rs2 ? o_ex_wb.result : i_id_ex.rs2_data;
    assign op_b    = i_id_ex.use_imm ? i_id_ex.imm : rs2_val;

    //////////////////////////////////////////////////
    // alu
    //////////////////////////////////////////////////

    always_comb
    begin
        case (i_id_ex.alu_op)
            ALU_ADD:  alu_out = op_a + op_b;
            ALU_SUB:  alu_out = op_a - op_b;
            ALU_SLL:  alu_out = op_a << op_b[4:0];
            ALU_SLT:  alu_out = XLEN'($signed(op_a) < $signed(op_b));
            ALU_SLTU: alu_out = XLEN'(op_a < op_b);
            ALU_XOR:  alu_out = op_a ^ op_b;
            ALU_SRL:  alu_out = op_a >> op_b[4:0];
            ALU_SRA:  alu_out = $signed(op_a) >>> op_b[4:0];
            ALU_OR:   alu_out = op_a | op_b;
            ALU_AND:  alu_out = op_a & op_b;
            default:  alu_out = op_b;
        endcase
    end

    // beq on equal, bne on differ
    assign o_redirect.valid  = i_id_ex.valid & i_id_ex.is_branch
                             & ((op_a == rs2_val) ^ i_id_ex.branch_ne);
    assign o_redirect.target = i_id_ex.pc + i_id_ex.imm;

    assign o_halt_req  = i_id_ex.valid & i_id_ex.is_ebreak;
    assign o_pipe_busy = i_id_ex.valid | o_ex_wb.valid;

    // execute to writeback, ebreak never retires
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            o_ex_wb.valid <= 1'b0;
        else
        begin
            o_ex_wb.valid  <= i_id_ex.valid & ~i_id_ex.is_ebreak;
            o_ex_wb.rd     <= i_id_ex.rd;
            o_ex_wb.wr_en  <= i_id_ex.wr_en;
            o_ex_wb.result <= alu_out;
        end
    end

endmodule

// ==== design/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         i_run,
    input  logic                         i_start,
    input  core_pkg::redirect_t          i_redirect,
    input  logic                         i_halt_req,
    input  logic                         i_imem_we,
    input  logic [core_pkg::IMEM_AW-1:0] i_imem_waddr,
    input  logic [core_pkg::XLEN-1:0]    i_imem_wdata,
    output core_pkg::if_id_t             o_if_id
);
    import core_pkg::*;

    logic [XLEN-1:0] imem [IMEM_WORDS];
    logic [XLEN-1:0] pc;
    logic            squash;

    // taken branch or ebreak in execute kills this fetch
    assign squash = i_redirect.valid | i_halt_req;

    //////////////////////////////////////////////////
    // instruction memory, host write port
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (i_imem_we)
            imem[i_imem_waddr] <= i_imem_wdata;
    end

    //////////////////////////////////////////////////
    // program counter
    //////////////////////////////////////////////////

    // static not-taken, branch target from execute
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            pc <= '0;
        else if (i_start)
            pc <= '0;
        else if (i_redirect.valid)
            pc <= i_redirect.target;
        else if (i_run)
            pc <= pc + XLEN'(4);
    end

    // fetch to decode register
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            o_if_id.valid <= 1'b0;
        else
        begin
            o_if_id.valid <= i_run & ~squash & ~i_start;
            o_if_id.pc    <= pc;
            // word index, pc wraps in the 64 words
            o_if_id.instr <= imem[pc[IMEM_AW+1:2]];
        end
    end

endmodule

// ==== design/host_csr_port.sv ====
`timescale 1ns/1ps

module host_csr_port (
    input  logic                         clk,
    input  logic                         rst_n,
    input  core_pkg::apb_req_t           i_apb,
    input  logic                         i_halt_req,
    input  logic                         i_pipe_busy,
    input  logic                         i_retire,
    input  logic [core_pkg::XLEN-1:0]    i_host_rdata,
    output core_pkg::apb_rsp_t           o_apb,
    output logic                         o_run,
    output logic                         o_start,
    output logic                         o_imem_we,
    output logic [core_pkg::IMEM_AW-1:0] o_imem_waddr,
    output logic [core_pkg::XLEN-1:0]    o_imem_wdata,
    output logic [core_pkg::REG_AW-1:0]  o_host_raddr
);
    import core_pkg::*;

    logic            access;
    logic            hit_imem, hit_ctrl, hit_status, hit_instret, hit_reg;
    logic            hit_any;
    logic            ro_write;
    logic            wr_ctrl;
    logic            halted;
    logic [XLEN-1:0] instret;

    //////////////////////////////////////////////////
    // apb decode
    //////////////////////////////////////////////////

    // second phase of a transfer, no wait states
    assign access = i_apb.psel & i_apb.penable;

    assign hit_imem    = (i_apb.paddr[APB_AW-1:8] == ADDR_IMEM_BASE[APB_AW-1:8]);
    assign hit_ctrl    = (i_apb.paddr == ADDR_CTRL);
    assign hit_status  = (i_apb.paddr == ADDR_STATUS);
    assign hit_instret = (i_apb.paddr == ADDR_INSTRET);
    assign hit_reg     = (i_apb.paddr[APB_AW-1:7] == ADDR_REG_BASE[APB_AW-1:7]);
    assign hit_any     = hit_imem | hit_ctrl | hit_status | hit_instret | hit_reg;

    // status, instret and register space are read only
    assign ro_write = i_apb.pwrite & (hit_status | hit_instret | hit_reg);

    assign o_apb.pready  = access;
    // imem is locked while the core runs
    assign o_apb.pslverr = access & (~hit_any | ro_write | (i_apb.pwrite & hit_imem & o_run));

    assign o_apb.prdata = hit_ctrl    ? XLEN'(o_run) :
                          hit_status  ? XLEN'({halted, o_run}) :
                          hit_instret ? instret :
                          hit_reg     ? i_host_rdata : '0;

    assign wr_ctrl = access & i_apb.pwrite & hit_ctrl;
    // run set also restarts pc, halted and instret
    assign o_start = wr_ctrl & i_apb.pwdata[0];

    assign o_imem_we    = access & i_apb.pwrite & hit_imem & ~o_run;
    assign o_imem_waddr = i_apb.paddr[IMEM_AW+1:2];
    assign o_imem_wdata = i_apb.pwdata;
    assign o_host_raddr = i_apb.paddr[REG_AW+1:2];

    //////////////////////////////////////////////////
    // run control and counters
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            o_run   <= 1'b0;
            halted  <= 1'b0;
            instret <= '0;
        end
        else
        begin
            // host write wins over ebreak
            if (wr_ctrl)
                o_run <= i_apb.pwdata[0];
            else if (i_halt_req)
                o_run <= 1'b0;

            // halted once stopped and drained
            if (o_start)
                halted <= 1'b0;
            else
                halted <= ~o_run & ~i_pipe_busy;

            if (o_start)
                instret <= '0;
            else if (i_retire)
                instret <= instret + XLEN'(1);
        end
    end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [core_pkg::REG_AW-1:0] i_rs1_addr,
    input  logic [core_pkg::REG_AW-1:0] i_rs2_addr,
    input  logic [core_pkg::REG_AW-1:0] i_host_raddr,
    input  core_pkg::rf_wr_t            i_wr,
    output logic [core_pkg::XLEN-1:0]   o_rs1_data,
    output logic [core_pkg::XLEN-1:0]   o_rs2_data,
    output logic [core_pkg::XLEN-1:0]   o_host_rdata
);
    import core_pkg::*;

    // x1..x31, x0 reads as zero
    logic [XLEN-1:0] regs [1:(1 << REG_AW) - 1];

    // write-through, same cycle write is seen by the reader
    function automatic logic [XLEN-1:0] read_port(input logic [REG_AW-1:0] addr);
        if (addr == '0)
            return '0;
        if (i_wr.en && i_wr.addr == addr)
            return i_wr.data;
        return regs[addr];
    endfunction

    always_comb
    begin
        o_rs1_data   = read_port(i_rs1_addr);
        o_rs2_data   = read_port(i_rs2_addr);
        o_host_rdata = read_port(i_host_raddr);
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 1; i < (1 << REG_AW); i++)
                regs[i] <= '0;
        end
        else if (i_wr.en && i_wr.addr != '0)
            regs[i_wr.addr] <= i_wr.data;
    end

endmodule

// ==== design/rv_pipe_top.sv ====
`timescale 1ns/1ps

module rv_pipe_top (
    input  logic               clk,
    input  logic               rst_n,
    input  core_pkg::apb_req_t i_apb,
    output core_pkg::apb_rsp_t o_apb
);
    import core_pkg::*;

    //////////////////////////////////////////////////
    // stage registers and control
    //////////////////////////////////////////////////

    if_id_t              if_id;
    id_ex_t              id_ex;
    ex_wb_t              ex_wb;
    redirect_t           redirect;
    rf_wr_t              rf_wr;
    logic                run, start, halt_req, ex_busy;
    logic                imem_we;
    logic [IMEM_AW-1:0]  imem_waddr;
    logic [XLEN-1:0]     imem_wdata;
    logic [REG_AW-1:0]   rs1_addr, rs2_addr, host_raddr;
    logic [XLEN-1:0]     rs1_data, rs2_data, host_rdata;

    // writeback port into the register file
    assign rf_wr = '{en: ex_wb.valid & ex_wb.wr_en, addr: ex_wb.rd, data: ex_wb.result};

    host_csr_port u_host (
        .clk(clk), .rst_n(rst_n), .i_apb(i_apb), .i_halt_req(halt_req),
        .i_pipe_busy(ex_busy | if_id.valid), .i_retire(ex_wb.valid),
        .i_host_rdata(host_rdata), .o_apb(o_apb), .o_run(run), .o_start(start),
        .o_imem_we(imem_we), .o_imem_waddr(imem_waddr), .o_imem_wdata(imem_wdata),
        .o_host_raddr(host_raddr)
    );

    fetch_stage u_fetch (
        .clk(clk), .rst_n(rst_n), .i_run(run), .i_start(start), .i_redirect(redirect),
        .i_halt_req(halt_req), .i_imem_we(imem_we), .i_imem_waddr(imem_waddr),
        .i_imem_wdata(imem_wdata), .o_if_id(if_id)
    );

    // squash kills the two younger instructions
    decode_stage u_decode (
        .clk(clk), .rst_n(rst_n), .i_if_id(if_id), .i_squash(redirect.valid | halt_req),
        .i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .o_rs1_addr(rs1_addr),
        .o_rs2_addr(rs2_addr), .o_id_ex(id_ex)
    );

    reg_file u_rf (
        .clk(clk), .rst_n(rst_n), .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr),
        .i_host_raddr(host_raddr), .i_wr(rf_wr), .o_rs1_data(rs1_data),
        .o_rs2_data(rs2_data), .o_host_rdata(host_rdata)
    );

    execute_stage u_execute (
        .clk(clk), .rst_n(rst_n), .i_id_ex(id_ex), .o_ex_wb(ex_wb),
        .o_redirect(redirect), .o_halt_req(halt_req), .o_pipe_busy(ex_busy)
    );

endmodule

// ==== sources.f ====
design/core_pkg.sv
design/host_csr_port.sv
design/fetch_stage.sv
design/decode_stage.sv
design/reg_file.sv
design/execute_stage.sv
design/rv_pipe_top.sv
testbench/rv_pipe_chk.sv
testbench/tb_rv_pipe.sv

// ==== testbench/rv_pipe_chk.sv ====
`timescale 1ns/1ps

module rv_pipe_chk (
    input logic               clk,
    input logic               rst_n,
    input core_pkg::apb_req_t i_apb,
    input core_pkg::apb_rsp_t i_apb_rsp,
    input logic               i_run,
    input logic               i_halt_req,
    input logic               i_redirect_valid,
    input logic               i_id_ex_valid
);

    // count of assertion failures, watched by the testbench
    int fail_cnt = 0;

    //////////////////////////////////////////////////
    // apb response
    //////////////////////////////////////////////////

    // no wait states, pready marks every access cycle
    a_pready: assert property (@(posedge clk) disable iff (!rst_n)
        i_apb_rsp.pready == (i_apb.psel & i_apb.penable))
    else
    begin
        $error("pready does not follow the access phase");
        fail_cnt++;
    end

    a_pslverr: assert property (@(posedge clk) disable iff (!rst_n)
        i_apb_rsp.pslverr |-> (i_apb.psel & i_apb.penable))
    else
    begin
        $error("pslverr outside an access cycle");
        fail_cnt++;
    end

    //////////////////////////////////////////////////
    // pipeline control
    //////////////////////////////////////////////////

    // taken branch or ebreak kills the decode slot
    a_squash: assert property (@(posedge clk) disable iff (!rst_n)
        (i_redirect_valid | i_halt_req) |=> !i_id_ex_valid)
    else
    begin
        $error("decode to execute entry survived a squash");
        fail_cnt++;
    end

    a_run_reset: assert property (@(posedge clk) !rst_n |=> !i_run)
    else
    begin
        $error("run is set right after reset");
        fail_cnt++;
    end

endmodule

bind rv_pipe_top rv_pipe_chk u_chk (
    .clk(clk), .rst_n(rst_n), .i_apb(i_apb), .i_apb_rsp(o_apb), .i_run(run),
    .i_halt_req(halt_req), .i_redirect_valid(redirect.valid), .i_id_ex_valid(id_ex.valid)
);

// ==== testbench/tb_rv_pipe.sv ====
`timescale 1ns/1ps

module tb_rv_pipe;
    import core_pkg::*;

    localparam int CHAIN_LEN  = 40;
    localparam int LOOP_ITERS = 5;
    localparam logic [11:0] MARK = 12'h6ad;
    // issued instructions of the chain and branch programs
    localparam int RUN_CYCLES = (CHAIN_LEN + 5) + (8 + 3 * LOOP_ITERS);
    // two bubbles per taken branch and per ebreak
    localparam int BUBBLES    = 2 * (LOOP_ITERS + 2) + 2 * 2;
    // loads, starts, probes, status polls and readback
    localparam int APB_XFERS  = (CHAIN_LEN + 5) + 20 + 5 + RUN_CYCLES / 3 + 4 + 2 * 35;
    // three cycles per transfer, doubled for margin
    localparam int CYCLE_LIMIT = 2 * (10 + RUN_CYCLES + BUBBLES + 3 * APB_XFERS);

    logic        clk = 1'b0;
    logic        rst_n;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic [31:0] prog [64];
    logic [31:0] mregs [32];
    logic [31:0] rng = 32'd2270;
    int          cycles = 0;

    rv_pipe_top u_dut (.clk(clk), .rst_n(rst_n), .i_apb(apb_req), .o_apb(apb_rsp));

    always #10 clk = ~clk;

    // run limit and bound assertion watch
    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout after %0d cycles, the core never reported halted", cycles);
            $display("Test failed");
            $fatal(1);
        end
        else if (u_dut.u_chk.fail_cnt != 0)
        begin
            $display("a concurrent assertion in rv_pipe_chk failed at %0t", $time);
            $display("Test failed");
            $fatal(1);
        end
    end

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    //////////////////////////////////////////////////
    // random numbers and encoders
    //////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_next();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_lui(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    // byte offset, beq f3 0 and bne f3 1
    function automatic logic [31:0] enc_b(input int off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], OPC_BRANCH};
    endfunction

    //////////////////////////////////////////////////
    // reference model, one instruction at a time
    //////////////////////////////////////////////////

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        logic [4:0]         sh;
        sa = a;
        sh = b[4:0];
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return {31'b0, sa < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:
            begin
                // sra copies the sign bit in
                if (alt)
                    return sa >>> sh;
                return a >> sh;
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // runs prog from pc 0 up to ebreak, updates mregs
    task automatic run_model(output int retired);
        logic [31:0] pc, next_pc, w, a, b, imm, res;
        logic [2:0]  f3;
        logic        wr;
        retired = 0;
        pc      = '0;
        for (int step = 0; step < 1000; step++)
        begin
            w = prog[pc[7:2]];
            if (w == INSTR_EBREAK)
                break;
            f3      = w[14:12];
            a       = mregs[w[19:15]];
            b       = mregs[w[24:20]];
            imm     = {{20{w[31]}}, w[31:20]};
            next_pc = pc + 32'd4;
            wr      = 1'b1;
            res     = '0;
            case (w[6:0])
                OPC_LUI:    res = {w[31:12], 12'b0};
                OPC_OP:     res = alu_ref(f3, w[30], a, b);
                OPC_OP_IMM: res = alu_ref(f3, w[30] & (f3 == 3'd5), a, imm);
                default:
                begin
                    // beq or bne
                    wr = 1'b0;
                    if ((a == b) != f3[0])
                        next_pc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                end
            endcase
            if (wr && w[11:7] != 5'd0)
                mregs[w[11:7]] = res;
            retired++;
            pc = next_pc;
        end
    endtask

    //////////////////////////////////////////////////
    // apb host
    //////////////////////////////////////////////////

    // setup, access, then one idle cycle
    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic load_prog(input int n);
        logic [31:0] rdat;
        logic        err;
        for (int i = 0; i < n; i++)
        begin
            apb_xfer(1'b1, ADDR_IMEM_BASE + 12'(4 * i), prog[i], rdat, err);
            check_eq("pslverr", 32'(err), 32'd0);
        end
    endtask

    task automatic start_core();
        logic [31:0] rdat;
        logic        err;
        apb_xfer(1'b1, ADDR_CTRL, 32'd1, rdat, err);
        check_eq("pslverr", 32'(err), 32'd0);
    endtask

    task automatic wait_halt();
        logic [31:0] st;
        logic        err;
        st = '0;
        while (!st[1])
            apb_xfer(1'b0, ADDR_STATUS, '0, st, err);
    endtask

    // status, run, instret and all registers against the model
    task automatic check_result();
        logic [31:0] rdat;
        logic        err;
        int          exp_ret;
        run_model(exp_ret);
        apb_xfer(1'b0, ADDR_STATUS, '0, rdat, err);
        check_eq("STATUS", rdat, 32'h2);
        apb_xfer(1'b0, ADDR_CTRL, '0, rdat, err);
        check_eq("CTRL", rdat, 32'h0);
        apb_xfer(1'b0, ADDR_INSTRET, '0, rdat, err);
        check_eq("INSTRET", rdat, 32'(exp_ret));
        for (int i = 0; i < 32; i++)
        begin
            apb_xfer(1'b0, ADDR_REG_BASE + 12'(4 * i), '0, rdat, err);
            check_eq($sformatf("x%0d", i), rdat, mregs[i]);
        end
    endtask

    //////////////////////////////////////////////////
    // programs
    //////////////////////////////////////////////////

    // each op reads the last one or two destinations
    task automatic build_chain();
        logic [31:0] r;
        logic [11:0] imm;
        logic [4:0]  rd, p1, p2;
        logic [2:0]  f3;
        prog[0] = enc_lui(20'(rand_next() >> 12), 5'd1);
        prog[1] = enc_i(12'(rand_next() >> 20), 5'd0, 3'd0, 5'd2);
        p1 = 5'd1;
        p2 = 5'd2;
        for (int i = 2; i < 2 + CHAIN_LEN; i++)
        begin
            rd = 5'd1 + 5'(rand_next() % 31);
            r  = rand_next();
            f3 = r[10:8];
            if (f3 == 3'd1)
                imm = {7'b0, r[20:16]};
            else if (f3 == 3'd5)
                imm = {1'b0, r[15], 5'b0, r[20:16]};
            else
                imm = r[31:20];
            case (r[13:11])
                3'd7:             prog[i] = enc_lui(r[31:12], rd);
                3'd4, 3'd5, 3'd6: prog[i] = enc_i(imm, p1, f3, rd);
                default:
                    prog[i] = enc_r((f3 == 3'd0 || f3 == 3'd5) ? {1'b0, r[14], 5'b0} : 7'b0,
                                    p2, p1, f3, rd);
            endcase
            p2 = p1;
            p1 = rd;
        end
        prog[CHAIN_LEN + 2] = INSTR_EBREAK;
        prog[CHAIN_LEN + 3] = enc_i(MARK, 5'd0, 3'd0, 5'd29);
        prog[CHAIN_LEN + 4] = enc_i(MARK, 5'd0, 3'd0, 5'd30);
    endtask

    // counted bne loop, beq taken and not taken, x0 writes
    task automatic build_branch();
        prog[0]  = enc_i(12'h123, 5'd0, 3'd0, 5'd0);
        prog[1]  = enc_i(12'(LOOP_ITERS), 5'd0, 3'd0, 5'd1);
        prog[2]  = enc_i(12'd0, 5'd0, 3'd0, 5'd2);
        prog[3]  = enc_i(12'd0, 5'd0, 3'd0, 5'd3);
        prog[4]  = enc_i(12'd1, 5'd2, 3'd0, 5'd2);
        prog[5]  = enc_r(7'd0, 5'd2, 5'd3, 3'd0, 5'd3);
        prog[6]  = enc_b(-8, 5'd1, 5'd2, 3'd1);
        prog[7]  = enc_b(12, 5'd1, 5'd2, 3'd0);
        prog[8]  = enc_i(MARK, 5'd0, 3'd0, 5'd20);
        prog[9]  = enc_i(MARK, 5'd0, 3'd0, 5'd21);
        prog[10] = enc_b(8, 5'd0, 5'd1, 3'd0);
        prog[11] = enc_i(12'd7, 5'd0, 3'd0, 5'd22);
        prog[12] = enc_b(12, 5'd0, 5'd22, 3'd1);
        prog[13] = enc_i(MARK, 5'd0, 3'd0, 5'd23);
        prog[14] = enc_i(MARK, 5'd0, 3'd0, 5'd24);
        // x0 write, then a read of x0 right behind it
        prog[15] = enc_r(7'd0, 5'd3, 5'd3, 3'd0, 5'd0);
        prog[16] = enc_r(7'd0, 5'd3, 5'd0, 3'd0, 5'd25);
        prog[17] = INSTR_EBREAK;
        prog[18] = enc_i(MARK, 5'd0, 3'd0, 5'd26);
        prog[19] = enc_i(MARK, 5'd0, 3'd0, 5'd28);
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial
    begin
        logic [31:0] rdat;
        logic        err;
        apb_req = '0;
        rst_n   = 1'b0;
        for (int i = 0; i < 32; i++)
            mregs[i] = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // unmapped read, write to status
        apb_xfer(1'b0, 12'h10c, '0, rdat, err);
        check_eq("pslverr", 32'(err), 32'd1);
        apb_xfer(1'b1, ADDR_STATUS, 32'h3, rdat, err);
        check_eq("pslverr", 32'(err), 32'd1);

        // dependent chain, imem locked while running
        build_chain();
        load_prog(CHAIN_LEN + 5);
        start_core();
        apb_xfer(1'b1, ADDR_IMEM_BASE + 12'(4 * 10), enc_i(12'h123, 5'd0, 3'd0, 5'd5),
                 rdat, err);
        check_eq("pslverr", 32'(err), 32'd1);
        wait_halt();
        check_result();

        // branches, x0 and code after ebreak
        build_branch();
        load_prog(20);
        start_core();
        wait_halt();
        check_result();

        if (u_dut.u_chk.fail_cnt == 0)
        begin
            $display("Test passed");
            $finish;
        end
        else
        begin
            $display("Test failed");
            $fatal(1);
        end
    end

endmodule
